// ==== glb_cfg_bus_slice.sv ====
//##########################################################################
// West bus register stage, east forwarding and local access decode
//##########################################################################

`default_nettype none
`timescale 1ns/1ps

`include "glb_tile_cfg_defines.svh"

module glb_cfg_bus_slice (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [`GLB_TILE_ID_WIDTH-1:0]   glb_tile_id,

    // From west neighbor
    input  logic                            cfg_wst_wr_en,
    input  logic                            cfg_wst_rd_en,
    input  logic [`GLB_CFG_ADDR_WIDTH-1:0]  cfg_wst_addr,
    input  logic [`GLB_DATA_WIDTH-1:0]      cfg_wst_wr_data,

    // To east neighbor
    output logic                            cfg_est_wr_en,
    output logic                            cfg_est_rd_en,
    output logic [`GLB_CFG_ADDR_WIDTH-1:0]  cfg_est_addr,
    output logic [`GLB_DATA_WIDTH-1:0]      cfg_est_wr_data,

    glb_cfg_reg_ifc.slice                   reg_if
);

    logic                           wr_en_q;
    logic                           rd_en_q;
    logic [`GLB_CFG_ADDR_WIDTH-1:0] addr_q;
    logic [`GLB_DATA_WIDTH-1:0]     wr_data_q;
    logic                           tile_hit;

    // One register stage on the whole bus
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_en_q   <= 1'b0;
            rd_en_q   <= 1'b0;
            addr_q    <= '0;
            wr_data_q <= '0;
        end else begin
            wr_en_q   <= cfg_wst_wr_en;
            rd_en_q   <= cfg_wst_rd_en;
            addr_q    <= cfg_wst_addr;
            wr_data_q <= cfg_wst_wr_data;
        end
    end

    // Every access goes east, local or not
    assign cfg_est_wr_en   = wr_en_q;
    assign cfg_est_rd_en   = rd_en_q;
    assign cfg_est_addr    = addr_q;
    assign cfg_est_wr_data = wr_data_q;

    // Upper address bits select the tile
    assign tile_hit = (addr_q[`GLB_CFG_ADDR_WIDTH-1 -: `GLB_TILE_ID_WIDTH] == glb_tile_id);

    assign reg_if.wr_en    = wr_en_q & tile_hit;
    assign reg_if.rd_en    = rd_en_q & tile_hit;
    assign reg_if.reg_addr = addr_q[`GLB_REG_ADDR_WIDTH-1:0];
    assign reg_if.wr_data  = wr_data_q;

endmodule

`default_nettype wire

// ==== glb_cfg_rd_return.sv ====
//##########################################################################
// Read return toward the west, local data ahead of the east chain
//##########################################################################

`default_nettype none
`timescale 1ns/1ps

`include "glb_tile_cfg_defines.svh"

module glb_cfg_rd_return (
    input  logic                       clk,
    input  logic                       arst_n,

    // Local target read data
    input  logic [`GLB_DATA_WIDTH-1:0] ctrl_rd_data,
    input  logic [`GLB_DATA_WIDTH-1:0] st_rd_data,
    input  logic [`GLB_DATA_WIDTH-1:0] ld_rd_data,

    // Return from east neighbor
    input  logic [`GLB_DATA_WIDTH-1:0] cfg_est_rd_data,
    input  logic                       cfg_est_rd_data_valid,

    glb_cfg_reg_ifc.monitor            reg_if,

    // Back to west neighbor
    output logic [`GLB_DATA_WIDTH-1:0] cfg_wst_rd_data,
    output logic                       cfg_wst_rd_data_valid
);

    glb_tile_cfg_pkg::cfg_op_e op;

    always_comb begin
        if (reg_if.rd_en) begin
            op = glb_tile_cfg_pkg::CFG_READ;
        end else if (reg_if.wr_en) begin
            op = glb_tile_cfg_pkg::CFG_WRITE;
        end else begin
            op = glb_tile_cfg_pkg::CFG_NOP;
        end
    end

    // Targets drive zero when not addressed, so an OR merges them
    // and an unmapped read returns zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg_wst_rd_data       <= '0;
            cfg_wst_rd_data_valid <= 1'b0;
        end else if (op == glb_tile_cfg_pkg::CFG_READ) begin
            cfg_wst_rd_data       <= ctrl_rd_data | st_rd_data | ld_rd_data;
            cfg_wst_rd_data_valid <= 1'b1;
        end else begin
            cfg_wst_rd_data       <= cfg_est_rd_data;
            cfg_wst_rd_data_valid <= cfg_est_rd_data_valid;
        end
    end

endmodule

`default_nettype wire

// ==== glb_cfg_reg_ifc.sv ====
//##########################################################################
// Decoded local register access inside one tile
//##########################################################################

`default_nettype none
`timescale 1ns/1ps

`include "glb_tile_cfg_defines.svh"

interface glb_cfg_reg_ifc;

    // Strobes already qualified by the tile id match
    logic                           wr_en;
    logic                           rd_en;
    logic [`GLB_REG_ADDR_WIDTH-1:0] reg_addr;
    logic [`GLB_DATA_WIDTH-1:0]     wr_data;

    modport slice (
        output wr_en, rd_en, reg_addr, wr_data
    );

    modport target (
        input wr_en, rd_en, reg_addr, wr_data
    );

    // Sees only the kind of access
    modport monitor (
        input wr_en, rd_en
    );

endinterface

`default_nettype wire

// ==== glb_dma_header_queue.sv ====
//##########################################################################
// Queue of DMA header registers with per-entry hardware invalidate
//##########################################################################

`default_nettype none
`timescale 1ns/1ps

`include "glb_tile_cfg_defines.svh"

module glb_dma_header_queue #(
    parameter int HDR_BASE = int'(glb_tile_cfg_pkg::REG_ST_HDR_BASE)
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [`GLB_QUEUE_DEPTH-1:0]   invalidate_pulse,

    glb_cfg_reg_ifc.target                reg_if,

    output logic [`GLB_DATA_WIDTH-1:0]    rd_data,
    output glb_tile_cfg_pkg::dma_header_t header [`GLB_QUEUE_DEPTH]
);

    localparam int IDX_W = $clog2(`GLB_QUEUE_DEPTH);
    localparam logic [`GLB_REG_ADDR_WIDTH-1:0] BASE_ADDR = `GLB_REG_ADDR_WIDTH'(HDR_BASE);
    // Four words per entry
    localparam logic [`GLB_REG_ADDR_WIDTH-1:0] WIN_SIZE =
        `GLB_REG_ADDR_WIDTH'(4 * `GLB_QUEUE_DEPTH);

    localparam logic [1:0] OFF_VALIDATE   = 2'd0;
    localparam logic [1:0] OFF_START_ADDR = 2'd1;
    localparam logic [1:0] OFF_NUM_WORDS  = 2'd2;

    glb_tile_cfg_pkg::dma_header_t    hdr_q [`GLB_QUEUE_DEPTH];
    logic [`GLB_REG_ADDR_WIDTH-1:0]   rel_addr;
    logic                             hit;
    logic [IDX_W-1:0]                 entry;
    logic [1:0]                       offset;

    // Wrapping subtract, so one compare covers the window
    assign rel_addr = reg_if.reg_addr - BASE_ADDR;
    assign hit      = (rel_addr < WIN_SIZE);
    assign entry    = rel_addr[IDX_W+1:2];
    assign offset   = rel_addr[1:0];

    for (genvar g = 0; g < `GLB_QUEUE_DEPTH; g++) begin : g_entry
        logic wr_sel;

        assign wr_sel = reg_if.wr_en && hit && (entry == IDX_W'(g));

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                hdr_q[g] <= '0;
            end else begin
                if (wr_sel) begin
                    case (offset)
                        OFF_VALIDATE:   hdr_q[g].valid <= reg_if.wr_data[0];
                        OFF_START_ADDR: hdr_q[g].start_addr <=
                                            reg_if.wr_data[`GLB_ADDR_WIDTH-1:0];
                        OFF_NUM_WORDS:  hdr_q[g].num_words <=
                                            reg_if.wr_data[`GLB_NUM_WORDS_WIDTH-1:0];
                        default:        ;
                    endcase
                end
                // DMA side clear beats a software validate
                if (invalidate_pulse[g]) begin
                    hdr_q[g].valid <= 1'b0;
                end
            end
        end

        assign header[g] = hdr_q[g];
    end

    always_comb begin
        rd_data = '0;
        if (reg_if.rd_en && hit) begin
            case (offset)
                OFF_VALIDATE:   rd_data[0] = hdr_q[entry].valid;
                OFF_START_ADDR: rd_data[`GLB_ADDR_WIDTH-1:0] = hdr_q[entry].start_addr;
                OFF_NUM_WORDS:  rd_data[`GLB_NUM_WORDS_WIDTH-1:0] = hdr_q[entry].num_words;
                default:        rd_data = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== glb_tile_cfg.sv ====
//##########################################################################
// Tile configuration block top: bus slice, registers, queues, read return
//##########################################################################

`default_nettype none
`timescale 1ns/1ps

`include "glb_tile_cfg_defines.svh"

module glb_tile_cfg (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [`GLB_TILE_ID_WIDTH-1:0]   glb_tile_id,

    // West side
    input  logic                            cfg_wst_wr_en,
    input  logic                            cfg_wst_rd_en,
    input  logic [`GLB_CFG_ADDR_WIDTH-1:0]  cfg_wst_addr,
    input  logic [`GLB_DATA_WIDTH-1:0]      cfg_wst_wr_data,
    output logic [`GLB_DATA_WIDTH-1:0]      cfg_wst_rd_data,
    output logic                            cfg_wst_rd_data_valid,

    // East side
    output logic                            cfg_est_wr_en,
    output logic                            cfg_est_rd_en,
    output logic [`GLB_CFG_ADDR_WIDTH-1:0]  cfg_est_addr,
    output logic [`GLB_DATA_WIDTH-1:0]      cfg_est_wr_data,
    input  logic [`GLB_DATA_WIDTH-1:0]      cfg_est_rd_data,
    input  logic                            cfg_est_rd_data_valid,

    // Header clear from the DMA engines
    input  logic [`GLB_QUEUE_DEPTH-1:0]     cfg_st_dma_invalidate_pulse,
    input  logic [`GLB_QUEUE_DEPTH-1:0]     cfg_ld_dma_invalidate_pulse,

    output logic                            cfg_tile_connected,
    output logic [1:0]                      cfg_strm_g2f_mux,
    output logic [1:0]                      cfg_strm_f2g_mux,
    output logic [1:0]                      cfg_ld_dma_mode,
    output logic [1:0]                      cfg_st_dma_mode,
    output logic [1:0]                      cfg_soft_reset_mux,
    output logic                            cfg_use_valid,
    output logic [`GLB_LATENCY_WIDTH-1:0]   cfg_latency,
    output glb_tile_cfg_pkg::dma_header_t   cfg_st_dma_header [`GLB_QUEUE_DEPTH],
    output glb_tile_cfg_pkg::dma_header_t   cfg_ld_dma_header [`GLB_QUEUE_DEPTH]
);

    logic [`GLB_DATA_WIDTH-1:0] ctrl_rd_data;
    logic [`GLB_DATA_WIDTH-1:0] st_rd_data;
    logic [`GLB_DATA_WIDTH-1:0] ld_rd_data;

    glb_cfg_reg_ifc reg_if ();

    glb_cfg_bus_slice bus_slice (
        .clk             (clk),
        .arst_n          (arst_n),
        .glb_tile_id     (glb_tile_id),
        .cfg_wst_wr_en   (cfg_wst_wr_en),
        .cfg_wst_rd_en   (cfg_wst_rd_en),
        .cfg_wst_addr    (cfg_wst_addr),
        .cfg_wst_wr_data (cfg_wst_wr_data),
        .cfg_est_wr_en   (cfg_est_wr_en),
        .cfg_est_rd_en   (cfg_est_rd_en),
        .cfg_est_addr    (cfg_est_addr),
        .cfg_est_wr_data (cfg_est_wr_data),
        .reg_if          (reg_if.slice)
    );

    glb_tile_ctrl_regs ctrl_regs (
        .clk                (clk),
        .arst_n             (arst_n),
        .reg_if             (reg_if.target),
        .rd_data            (ctrl_rd_data),
        .cfg_tile_connected (cfg_tile_connected),
        .cfg_strm_g2f_mux   (cfg_strm_g2f_mux),
        .cfg_strm_f2g_mux   (cfg_strm_f2g_mux),
        .cfg_ld_dma_mode    (cfg_ld_dma_mode),
        .cfg_st_dma_mode    (cfg_st_dma_mode),
        .cfg_soft_reset_mux (cfg_soft_reset_mux),
        .cfg_use_valid      (cfg_use_valid),
        .cfg_latency        (cfg_latency)
    );

    glb_dma_header_queue #(
        .HDR_BASE (int'(glb_tile_cfg_pkg::REG_ST_HDR_BASE))
    ) st_queue (
        .clk              (clk),
        .arst_n           (arst_n),
        .invalidate_pulse (cfg_st_dma_invalidate_pulse),
        .reg_if           (reg_if.target),
        .rd_data          (st_rd_data),
        .header           (cfg_st_dma_header)
    );

    glb_dma_header_queue #(
        .HDR_BASE (int'(glb_tile_cfg_pkg::REG_LD_HDR_BASE))
    ) ld_queue (
        .clk              (clk),
        .arst_n           (arst_n),
        .invalidate_pulse (cfg_ld_dma_invalidate_pulse),
        .reg_if           (reg_if.target),
        .rd_data          (ld_rd_data),
        .header           (cfg_ld_dma_header)
    );

    glb_cfg_rd_return rd_return (
        .clk                   (clk),
        .arst_n                (arst_n),
        .ctrl_rd_data          (ctrl_rd_data),
        .st_rd_data            (st_rd_data),
        .ld_rd_data            (ld_rd_data),
        .cfg_est_rd_data       (cfg_est_rd_data),
        .cfg_est_rd_data_valid (cfg_est_rd_data_valid),
        .reg_if                (reg_if.monitor),
        .cfg_wst_rd_data       (cfg_wst_rd_data),
        .cfg_wst_rd_data_valid (cfg_wst_rd_data_valid)
    );

endmodule

`default_nettype wire

// ==== glb_tile_cfg_cases.txt ====
# op addr data expect, all hex; ops wr rd est fwd sinv linv chk
# chk addr: 0 control word, 1 latency, 1k store header k, 2k load header k
wr   140 fffff5a5 0
chk  0   0        5a5
wr   141 fffffff3 0
chk  1   0        13
rd   140 0        5a5
rd   141 0        13
wr   140 00000a5a 0
chk  0   0        a5a
rd   140 0        a5a
rd   142 0        0
rd   14b 0        0
wr   149 fff12345 0
wr   14a 00000100 0
wr   148 00000001 0
chk  10  0        923450100
wr   151 0007ffff 0
wr   152 0000ffff 0
wr   150 00000001 0
chk  12  0        fffffffff
wr   15d 00000abc 0
wr   15e 00000040 0
wr   15c 00000001 0
chk  21  0        80abc0040
wr   165 fff40000 0
wr   166 00001234 0
wr   164 00000001 0
chk  23  0        c00001234
rd   149 0        12345
rd   14a 0        100
rd   148 0        1
rd   166 0        1234
rd   165 0        40000
sinv 2   0        0
chk  12  0        7ffffffff
chk  10  0        923450100
rd   150 0        0
rd   151 0        7ffff
rd   148 0        1
linv 1   0        0
chk  21  0        0abc0040
chk  23  0        c00001234
rd   15c 0        0
rd   15d 0        abc
rd   164 0        1
fwd  0c0 00000fff 1
chk  0   0        a5a
fwd  2c8 deadbeef 1
fwd  3d5 0        0
chk  1   0        13
est  0   cafef00d cafef00d
rd   141 0        13
est  0   12345678 12345678

// ==== glb_tile_cfg_defines.svh ====
//##########################################################################
// Width and depth macros for the tile configuration block
//##########################################################################

`ifndef GLB_TILE_CFG_DEFINES_SVH
`define GLB_TILE_CFG_DEFINES_SVH

// Configuration bus
`define GLB_DATA_WIDTH      32
`define GLB_TILE_ID_WIDTH   4
`define GLB_REG_ADDR_WIDTH  6

// Tile id sits in the upper bits of the bus address
`define GLB_CFG_ADDR_WIDTH  (`GLB_TILE_ID_WIDTH + `GLB_REG_ADDR_WIDTH)

// Stream latency
`define GLB_LATENCY_WIDTH   5

// DMA header fields
`define GLB_ADDR_WIDTH      19
`define GLB_NUM_WORDS_WIDTH 16

// Headers per store or load queue
`define GLB_QUEUE_DEPTH     4

`endif

// ==== glb_tile_cfg_pkg.sv ====
//##########################################################################
// Bus opcode, register map, tile control word and DMA header types
//##########################################################################

`default_nettype none

`include "glb_tile_cfg_defines.svh"

package glb_tile_cfg_pkg;

    // Operation of the current local access
    typedef enum logic [1:0] {
        CFG_NOP   = 2'd0,
        CFG_WRITE = 2'd1,
        CFG_READ  = 2'd2
    } cfg_op_e;

    // Register word addresses inside one tile
    // Header k of a queue sits at base + 4k: +0 validate, +1 start_addr, +2 num_words
    typedef enum logic [`GLB_REG_ADDR_WIDTH-1:0] {
        REG_TILE_CTRL   = 6'd0,
        REG_LATENCY     = 6'd1,
        REG_ST_HDR_BASE = 6'd8,
        REG_LD_HDR_BASE = 6'd24
    } cfg_reg_e;

    // Tile control word
    //   bit 0      tile_connected
    //   bits 2:1   strm_g2f_mux
    //   bits 4:3   strm_f2g_mux
    //   bits 6:5   ld_dma_mode
    //   bits 8:7   st_dma_mode
    //   bits 10:9  soft_reset_mux
    //   bit 11     use_valid
    // Upper bits read as zero
    typedef struct packed {
        logic       use_valid;
        logic [1:0] soft_reset_mux;
        logic [1:0] st_dma_mode;
        logic [1:0] ld_dma_mode;
        logic [1:0] strm_f2g_mux;
        logic [1:0] strm_g2f_mux;
        logic       tile_connected;
    } tile_ctrl_t;

    // One store or load DMA header
    typedef struct packed {
        logic                            valid;
        logic [`GLB_ADDR_WIDTH-1:0]      start_addr;
        logic [`GLB_NUM_WORDS_WIDTH-1:0] num_words;
    } dma_header_t;

endpackage

`default_nettype wire

// ==== glb_tile_cfg_props.sv ====
//##########################################################################
// Bound assertions on east forwarding, read return and header invalidate
//##########################################################################

`default_nettype none
`timescale 1ns/1ps

`include "glb_tile_cfg_defines.svh"

module glb_tile_cfg_props (
    input logic                           clk,
    input logic                           arst_n,
    input logic [`GLB_TILE_ID_WIDTH-1:0]  glb_tile_id,
    input logic                           cfg_wst_wr_en,
    input logic                           cfg_wst_rd_en,
    input logic [`GLB_CFG_ADDR_WIDTH-1:0] cfg_wst_addr,
    input logic [`GLB_DATA_WIDTH-1:0]     cfg_wst_wr_data,
    input logic                           cfg_wst_rd_data_valid,
    input logic                           cfg_est_wr_en,
    input logic                           cfg_est_rd_en,
    input logic [`GLB_CFG_ADDR_WIDTH-1:0] cfg_est_addr,
    input logic [`GLB_DATA_WIDTH-1:0]     cfg_est_wr_data,
    input logic                           cfg_est_rd_data_valid,
    input logic [`GLB_QUEUE_DEPTH-1:0]    cfg_st_dma_invalidate_pulse,
    input logic [`GLB_QUEUE_DEPTH-1:0]    cfg_ld_dma_invalidate_pulse,
    input glb_tile_cfg_pkg::dma_header_t  cfg_st_dma_header [`GLB_QUEUE_DEPTH],
    input glb_tile_cfg_pkg::dma_header_t  cfg_ld_dma_header [`GLB_QUEUE_DEPTH]
);

    logic local_rd;

    assign local_rd = cfg_wst_rd_en &&
        (cfg_wst_addr[`GLB_CFG_ADDR_WIDTH-1 -: `GLB_TILE_ID_WIDTH] == glb_tile_id);

    // East side copies the west bus one cycle late
    a_east_fwd: assert property (@(posedge clk) disable iff (!arst_n)
        {cfg_est_wr_en, cfg_est_rd_en, cfg_est_addr, cfg_est_wr_data} ==
        $past({cfg_wst_wr_en, cfg_wst_rd_en, cfg_wst_addr, cfg_wst_wr_data}))
        else $error("east bus does not match the west bus of the previous cycle");

    a_valid_in_reset: assert property (@(posedge clk) !arst_n |-> !cfg_wst_rd_data_valid)
        else $error("read data valid high during reset");

    // An isolated local read gives a one-cycle valid pulse
    a_valid_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        local_rd ##1 !cfg_wst_rd_en ##1 !cfg_est_rd_data_valid
        |-> cfg_wst_rd_data_valid ##1 !cfg_wst_rd_data_valid)
        else $error("read data valid missing or longer than one cycle");

    for (genvar g = 0; g < `GLB_QUEUE_DEPTH; g++) begin : g_inv
        a_st_clear: assert property (@(posedge clk) disable iff (!arst_n)
            cfg_st_dma_invalidate_pulse[g] |=> !cfg_st_dma_header[g].valid)
            else $error("store header valid not cleared by invalidate");
        a_ld_clear: assert property (@(posedge clk) disable iff (!arst_n)
            cfg_ld_dma_invalidate_pulse[g] |=> !cfg_ld_dma_header[g].valid)
            else $error("load header valid not cleared by invalidate");
    end

endmodule

bind glb_tile_cfg glb_tile_cfg_props props0 (.*);

`default_nettype wire

// ==== glb_tile_ctrl_regs.sv ====
//##########################################################################
// Tile control and stream latency registers with read data
//##########################################################################

`default_nettype none
`timescale 1ns/1ps

`include "glb_tile_cfg_defines.svh"

module glb_tile_ctrl_regs (
    input  logic                           clk,
    input  logic                           arst_n,

    glb_cfg_reg_ifc.target                 reg_if,

    output logic [`GLB_DATA_WIDTH-1:0]     rd_data,

    // Register fields
    output logic                           cfg_tile_connected,
    output logic [1:0]                     cfg_strm_g2f_mux,
    output logic [1:0]                     cfg_strm_f2g_mux,
    output logic [1:0]                     cfg_ld_dma_mode,
    output logic [1:0]                     cfg_st_dma_mode,
    output logic [1:0]                     cfg_soft_reset_mux,
    output logic                           cfg_use_valid,
    output logic [`GLB_LATENCY_WIDTH-1:0]  cfg_latency
);

    localparam int CTRL_WIDTH = $bits(glb_tile_cfg_pkg::tile_ctrl_t);

    glb_tile_cfg_pkg::tile_ctrl_t        tile_ctrl_q;
    logic [`GLB_LATENCY_WIDTH-1:0]       latency_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tile_ctrl_q <= '0;
            latency_q   <= '0;
        end else if (reg_if.wr_en) begin
            if (reg_if.reg_addr == glb_tile_cfg_pkg::REG_TILE_CTRL) begin
                tile_ctrl_q <= glb_tile_cfg_pkg::tile_ctrl_t'(reg_if.wr_data[CTRL_WIDTH-1:0]);
            end
            if (reg_if.reg_addr == glb_tile_cfg_pkg::REG_LATENCY) begin
                latency_q <= reg_if.wr_data[`GLB_LATENCY_WIDTH-1:0];
            end
        end
    end

    // Zero unless this block is the one being read
    always_comb begin
        rd_data = '0;
        if (reg_if.rd_en) begin
            case (reg_if.reg_addr)
                glb_tile_cfg_pkg::REG_TILE_CTRL: rd_data = `GLB_DATA_WIDTH'(tile_ctrl_q);
                glb_tile_cfg_pkg::REG_LATENCY:   rd_data = `GLB_DATA_WIDTH'(latency_q);
                default:                         rd_data = '0;
            endcase
        end
    end

    // Field unpacking
    assign cfg_tile_connected = tile_ctrl_q.tile_connected;
    assign cfg_strm_g2f_mux   = tile_ctrl_q.strm_g2f_mux;
    assign cfg_strm_f2g_mux   = tile_ctrl_q.strm_f2g_mux;
    assign cfg_ld_dma_mode    = tile_ctrl_q.ld_dma_mode;
    assign cfg_st_dma_mode    = tile_ctrl_q.st_dma_mode;
    assign cfg_soft_reset_mux = tile_ctrl_q.soft_reset_mux;
    assign cfg_use_valid      = tile_ctrl_q.use_valid;
    assign cfg_latency        = latency_q;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the tile configuration testbench with Verilator
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_glb_tile_cfg &&
./obj_dir/Vtb_glb_tile_cfg | tee sim.log &&
grep -q "^Simulation PASSED" sim.log &&
echo "run.sh: test passed" ||
{ echo "run.sh: test failed"; exit 1; }

// ==== tb.f ====
+incdir+.
glb_tile_cfg_pkg.sv
glb_cfg_reg_ifc.sv
glb_cfg_bus_slice.sv
glb_tile_ctrl_regs.sv
glb_dma_header_queue.sv
glb_cfg_rd_return.sv
glb_tile_cfg.sv
glb_tile_cfg_props.sv
tb_glb_tile_cfg.sv

// ==== tb_glb_tile_cfg.sv ====
//##########################################################################
// Testbench for the tile configuration block driven by a case file
//##########################################################################

`default_nettype none
`timescale 1ns/1ps

`include "glb_tile_cfg_defines.svh"

module tb_glb_tile_cfg;

    localparam int RESET_CYCLES = 4;
    localparam logic [`GLB_TILE_ID_WIDTH-1:0] TILE_ID = 4'd5;

    logic                            clk;
    logic                            arst_n;
    logic                            cfg_wst_wr_en;
    logic                            cfg_wst_rd_en;
    logic [`GLB_CFG_ADDR_WIDTH-1:0]  cfg_wst_addr;
    logic [`GLB_DATA_WIDTH-1:0]      cfg_wst_wr_data;
    logic [`GLB_DATA_WIDTH-1:0]      cfg_wst_rd_data;
    logic                            cfg_wst_rd_data_valid;
    logic                            cfg_est_wr_en;
    logic                            cfg_est_rd_en;
    logic [`GLB_CFG_ADDR_WIDTH-1:0]  cfg_est_addr;
    logic [`GLB_DATA_WIDTH-1:0]      cfg_est_wr_data;
    logic [`GLB_DATA_WIDTH-1:0]      cfg_est_rd_data;
    logic                            cfg_est_rd_data_valid;
    logic [`GLB_QUEUE_DEPTH-1:0]     cfg_st_dma_invalidate_pulse;
    logic [`GLB_QUEUE_DEPTH-1:0]     cfg_ld_dma_invalidate_pulse;
    logic                            cfg_tile_connected;
    logic [1:0]                      cfg_strm_g2f_mux;
    logic [1:0]                      cfg_strm_f2g_mux;
    logic [1:0]                      cfg_ld_dma_mode;
    logic [1:0]                      cfg_st_dma_mode;
    logic [1:0]                      cfg_soft_reset_mux;
    logic                            cfg_use_valid;
    logic [`GLB_LATENCY_WIDTH-1:0]   cfg_latency;
    glb_tile_cfg_pkg::dma_header_t   cfg_st_dma_header [`GLB_QUEUE_DEPTH];
    glb_tile_cfg_pkg::dma_header_t   cfg_ld_dma_header [`GLB_QUEUE_DEPTH];

    // Case table of operation, address or selector, data and expected value
    logic [63:0] case_op [$];
    logic [63:0] case_a  [$];
    logic [63:0] case_d  [$];
    logic [63:0] case_e  [$];

    int errors      = 0;
    int checks      = 0;
    int cycles      = 0;
    int cycle_limit = 0;

    glb_tile_cfg dut0 (.glb_tile_id(TILE_ID), .*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic idle_bus();
        cfg_wst_wr_en               = 1'b0;
        cfg_wst_rd_en               = 1'b0;
        cfg_wst_addr                = '0;
        cfg_wst_wr_data             = '0;
        cfg_est_rd_data             = '0;
        cfg_est_rd_data_valid       = 1'b0;
        cfg_st_dma_invalidate_pulse = '0;
        cfg_ld_dma_invalidate_pulse = '0;
    endtask

    // Strobes last one cycle, then wait for the return toward the west
    task automatic wait_read_return(output int n);
        n = 0;
        do begin
            @(negedge clk);
            idle_bus();
            n++;
        end while (!cfg_wst_rd_data_valid);
    endtask

    // Selector 0 control word, 1 latency, 1k store header k, 2k load header k
    function automatic logic [63:0] output_value(input logic [63:0] sel);
        glb_tile_cfg_pkg::dma_header_t hdr;
        logic [63:0]                   v;
        v = '0;
        if (sel == 64'h0) begin
            v = 64'({cfg_use_valid, cfg_soft_reset_mux, cfg_st_dma_mode, cfg_ld_dma_mode,
                     cfg_strm_f2g_mux, cfg_strm_g2f_mux, cfg_tile_connected});
        end else if (sel == 64'h1) begin
            v = 64'(cfg_latency);
        end else begin
            hdr = (sel[7:4] == 4'h1) ? cfg_st_dma_header[sel[1:0]] : cfg_ld_dma_header[sel[1:0]];
            v   = 64'({hdr.valid, hdr.start_addr, hdr.num_words});
        end
        return v;
    endfunction

    function automatic string output_name(input logic [63:0] sel);
        if (sel == 64'h0) begin
            return "tile control fields";
        end else if (sel == 64'h1) begin
            return "cfg_latency";
        end else if (sel[7:4] == 4'h1) begin
            return $sformatf("cfg_st_dma_header[%0d]", sel[1:0]);
        end
        return $sformatf("cfg_ld_dma_header[%0d]", sel[1:0]);
    endfunction

    task automatic run_case(input logic [63:0] op, input logic [63:0] a,
                            input logic [63:0] d, input logic [63:0] e);
        int n;
        case (op)
            64'("wr"): begin
                cfg_wst_wr_en   = 1'b1;
                cfg_wst_addr    = `GLB_CFG_ADDR_WIDTH'(a);
                cfg_wst_wr_data = `GLB_DATA_WIDTH'(d);
                @(negedge clk);
                idle_bus();
            end
            64'("rd"): begin
                cfg_wst_rd_en = 1'b1;
                cfg_wst_addr  = `GLB_CFG_ADDR_WIDTH'(a);
                wait_read_return(n);
                check("cfg_wst_rd_data", 64'(cfg_wst_rd_data), e);
                check("local read latency", 64'(n), 64'd2);
            end
            64'("est"): begin
                cfg_est_rd_data       = `GLB_DATA_WIDTH'(d);
                cfg_est_rd_data_valid = 1'b1;
                wait_read_return(n);
                check("cfg_wst_rd_data", 64'(cfg_wst_rd_data), e);
                check("east return latency", 64'(n), 64'd1);
            end
            64'("fwd"): begin
                // Expected column is 1 for a write, 0 for a read
                cfg_wst_wr_en   = e[0];
                cfg_wst_rd_en   = !e[0];
                cfg_wst_addr    = `GLB_CFG_ADDR_WIDTH'(a);
                cfg_wst_wr_data = `GLB_DATA_WIDTH'(d);
                @(negedge clk);
                check("cfg_est_wr_en", 64'(cfg_est_wr_en), 64'(e[0]));
                check("cfg_est_rd_en", 64'(cfg_est_rd_en), 64'(!e[0]));
                check("cfg_est_addr", 64'(cfg_est_addr), 64'(`GLB_CFG_ADDR_WIDTH'(a)));
                check("cfg_est_wr_data", 64'(cfg_est_wr_data), 64'(`GLB_DATA_WIDTH'(d)));
                idle_bus();
                // Another tile's access returns nothing toward the west
                @(negedge clk);
                check("cfg_wst_rd_data_valid", 64'(cfg_wst_rd_data_valid), 64'd0);
            end
            64'("sinv"), 64'("linv"): begin
                if (op == 64'("sinv")) begin
                    cfg_st_dma_invalidate_pulse[a[1:0]] = 1'b1;
                end else begin
                    cfg_ld_dma_invalidate_pulse[a[1:0]] = 1'b1;
                end
                @(negedge clk);
                idle_bus();
            end
            64'("chk"): begin
                @(negedge clk);
                check(output_name(a), output_value(a), e);
            end
            default: begin
                errors++;
                $display("error: case file holds an unknown operation");
            end
        endcase
    endtask

    task automatic load_cases();
        int          fd;
        string       line;
        logic [63:0] op;
        logic [63:0] a;
        logic [63:0] d;
        logic [63:0] e;
        fd = $fopen("glb_tile_cfg_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file glb_tile_cfg_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // Skip comments and blank lines
                if (line.len() > 0 && line[0] != "#") begin
                    if ($sscanf(line, "%s %h %h %h", op, a, d, e) == 4) begin
                        case_op.push_back(op);
                        case_a.push_back(a);
                        case_d.push_back(d);
                        case_e.push_back(e);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin : main
        int total;
        total = 0;
        arst_n = 1'b0;
        idle_bus();
        load_cases();
        foreach (case_op[i]) begin
            total += (case_op[i] == 64'("rd") || case_op[i] == 64'("fwd")) ? 2 : 1;
        end
        cycle_limit = 2 * total + RESET_CYCLES + 2;
        if (case_op.size() == 0) begin
            errors++;
            $display("no cases were read, nothing was tested");
        end

        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        foreach (case_op[i]) begin
            run_case(case_op[i], case_a[i], case_d[i], case_e[i]);
        end
        @(negedge clk);

        $display("%0d cases, %0d checks, %0d errors", case_op.size(), checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
